// File: src/link_pkg.sv
`default_nettype none

package link_pkg;

  // ##########################################################
  // Phases and lane types
  // ##########################################################

  typedef enum logic [1:0] {
    INIT          = 2'd0,
    DELAY_ADJUST  = 2'd1,
    WORD_ALIGN    = 2'd2,
    DATA_TRANSFER = 2'd3
  } link_phase_e;

  localparam int BYTE_W = 8;
  typedef logic [BYTE_W-1:0] byte_t;

  localparam int CNT_W = 10;
  typedef logic [CNT_W-1:0] phase_cnt_t;

  // ##########################################################
  // Fixed training patterns
  // ##########################################################

  localparam byte_t ALIGN_BYTE  = 8'h93;  // Word-align marker
  localparam byte_t TOGGLE_BYTE = 8'hAA;  // Delay-adjust toggle

  // Open windows on the counter's next value
  localparam phase_cnt_t TOGGLE_LO   = 10'd32;
  localparam phase_cnt_t TOGGLE_HI   = 10'd224;
  localparam phase_cnt_t PHY_INIT_LO = 10'd64;
  localparam phase_cnt_t PHY_INIT_HI = 10'd196;

  // Test data LFSR, Galois form shifting right
  localparam byte_t PRBS_SEED = 8'h01;  // Must be nonzero
  localparam byte_t PRBS_TAPS = 8'hB8;

endpackage

`default_nettype wire

// File: src/link_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface link_ctrl_if;
  import link_pkg::*;

  link_phase_e phase_next;  // Phase after this cycle's decision
  phase_cnt_t  cnt_next;
  logic        pull;        // Sink pulls this cycle
  logic        clear;       // Synchronous restart
  logic        advance;     // Data byte taken
  logic        send;        // Byte taken, any phase but INIT

  modport ctrl (
    output phase_next,
    output cnt_next,
    output pull,
    output clear,
    output advance,
    output send
  );

  // Training patterns need the phase and window position
  modport pattern (
    input phase_next,
    input cnt_next,
    input clear
  );

  modport prbs (
    input advance,
    input clear
  );

  modport lane (
    input pull,
    input advance,
    input send,
    input clear
  );

endinterface

`default_nettype wire

// File: src/link_train_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module link_train_ctrl #(
  parameter int INIT_LEN  = 64,
  parameter int DELAY_LEN = 256,
  parameter int DATA_LEN  = 1024
) (
  input  logic             CLK,
  input  logic             RSTX,
  input  logic             DOPULL,
  input  logic             CLR,
  link_ctrl_if.ctrl        ctl
);
  import link_pkg::*;

  // Counter loads, one less than the phase length
  localparam phase_cnt_t INIT_LOAD  = phase_cnt_t'(INIT_LEN - 1);
  localparam phase_cnt_t DELAY_LOAD = phase_cnt_t'(DELAY_LEN - 1);
  localparam phase_cnt_t DATA_LOAD  = phase_cnt_t'(DATA_LEN - 1);

  link_phase_e phase;
  link_phase_e phase_next;
  phase_cnt_t  cnt;
  phase_cnt_t  cnt_next;
  logic        cnt_zero;

  assign cnt_zero = (cnt == '0);

  // ##########################################################
  // Phase sequencing
  // ##########################################################

  always_comb begin
    phase_next = phase;
    if (DOPULL && cnt_zero) begin
      case (phase)
        INIT:          phase_next = DELAY_ADJUST;
        DELAY_ADJUST:  phase_next = WORD_ALIGN;
        WORD_ALIGN:    phase_next = DATA_TRANSFER;
        DATA_TRANSFER: phase_next = DELAY_ADJUST;  // Loop forever
        default:       phase_next = INIT;
      endcase
    end
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      phase <= INIT;
    end else if (CLR) begin
      phase <= INIT;
    end else begin
      phase <= phase_next;
    end
  end

  // ##########################################################
  // Phase counter, moves on pulled cycles only
  // ##########################################################

  always_comb begin
    if (!DOPULL) begin
      cnt_next = cnt;  // Hold under back-pressure
    end else if (phase_next != phase) begin
      case (phase_next)
        DELAY_ADJUST:  cnt_next = DELAY_LOAD;
        WORD_ALIGN:    cnt_next = '0;  // Single byte
        DATA_TRANSFER: cnt_next = DATA_LOAD;
        default:       cnt_next = '0;
      endcase
    end else begin
      cnt_next = cnt - 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      cnt <= INIT_LOAD;
    end else if (CLR) begin
      cnt <= INIT_LOAD;
    end else begin
      cnt <= cnt_next;
    end
  end

  // Decisions shared with the datapath
  assign ctl.phase_next = phase_next;
  assign ctl.cnt_next   = cnt_next;
  assign ctl.pull       = DOPULL;
  assign ctl.clear      = CLR;
  assign ctl.advance    = DOPULL && (phase_next == DATA_TRANSFER);
  assign ctl.send       = DOPULL && (phase_next != INIT);

endmodule

`default_nettype wire

// File: src/train_pattern_gen.sv
`timescale 1ns/10ps
`default_nettype none

module train_pattern_gen (
  input  logic             CLK,
  input  logic             RSTX,
  link_ctrl_if.pattern     ctl,
  output link_pkg::byte_t  pattern_byte,
  output logic             PHY_INIT
);
  import link_pkg::*;

  logic in_delay;
  logic toggle_win;
  logic phy_init_win;

  assign in_delay = (ctl.phase_next == DELAY_ADJUST);

  // Both windows exclude their bounds
  assign toggle_win   = (ctl.cnt_next > TOGGLE_LO) && (ctl.cnt_next < TOGGLE_HI);
  assign phy_init_win = (ctl.cnt_next > PHY_INIT_LO) && (ctl.cnt_next < PHY_INIT_HI);

  // ##########################################################
  // Training byte for the current phase
  // ##########################################################

  always_comb begin
    case (ctl.phase_next)
      DELAY_ADJUST: begin
        if (toggle_win) begin
          pattern_byte = TOGGLE_BYTE;
        end else begin
          pattern_byte = '0;  // Quiet edges of the window
        end
      end
      WORD_ALIGN: pattern_byte = ALIGN_BYTE;
      default:    pattern_byte = '0;
    endcase
  end

  // Strobe for far-end deskew, stays put while the sink pauses
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      PHY_INIT <= 1'b0;
    end else if (ctl.clear) begin
      PHY_INIT <= 1'b0;
    end else begin
      PHY_INIT <= in_delay && phy_init_win;
    end
  end

endmodule

`default_nettype wire

// File: src/prbs_byte_gen.sv
`timescale 1ns/10ps
`default_nettype none

module prbs_byte_gen (
  input  logic             CLK,
  input  logic             RSTX,
  link_ctrl_if.prbs        ctl,
  output link_pkg::byte_t  prbs_next
);
  import link_pkg::*;

  byte_t state;
  byte_t step1;

  // One Galois step, feedback taken from the bit shifted out
  function automatic byte_t lfsr_step(input byte_t s);
    byte_t r;
    r = s >> 1;
    if (s[0]) begin
      r = r ^ PRBS_TAPS;
    end
    return r;
  endfunction

  // Two steps per data byte
  assign step1     = lfsr_step(state);
  assign prbs_next = lfsr_step(step1);

  // Runs on across loops, only reset or clear reseeds
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      state <= PRBS_SEED;
    end else if (ctl.clear) begin
      state <= PRBS_SEED;
    end else if (ctl.advance) begin
      state <= prbs_next;
    end
  end

endmodule

`default_nettype wire

// File: src/tx_lane_out.sv
`timescale 1ns/10ps
`default_nettype none

module tx_lane_out (
  input  logic             CLK,
  input  logic             RSTX,
  link_ctrl_if.lane        ctl,
  input  link_pkg::byte_t  pattern_byte,
  input  link_pkg::byte_t  prbs_next,
  output link_pkg::byte_t  DOUT,
  output logic             DOPUSH
);

  // ##########################################################
  // Output register stage
  // ##########################################################

  // Loads on pulled cycles only, so DOUT keeps the last byte in pauses
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      DOUT <= '0;
    end else if (ctl.clear) begin
      DOUT <= '0;
    end else if (ctl.pull) begin
      if (ctl.advance) begin
        DOUT <= prbs_next;     // Test data
      end else begin
        DOUT <= pattern_byte;  // Training or idle
      end
    end
  end

  // Valid one cycle after the pull
  always_ff @(posedge CLK or negedge RSTX) begin
    if (!RSTX) begin
      DOPUSH <= 1'b0;
    end else if (ctl.clear) begin
      DOPUSH <= 1'b0;
    end else begin
      DOPUSH <= ctl.send;
    end
  end

endmodule

`default_nettype wire

// File: src/link_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

module link_tx_top #(
  parameter int INIT_LEN  = 64,
  parameter int DELAY_LEN = 256,   // At least 225 for the toggle window
  parameter int DATA_LEN  = 1024
) (
  input  logic             CLK,
  input  logic             RSTX,
  input  logic             DOPULL,
  input  logic             CLR,
  output logic             DOPUSH,
  output logic             PHY_INIT,
  output link_pkg::byte_t  DOUT
);

  link_pkg::byte_t pattern_byte;
  link_pkg::byte_t prbs_next;

  link_ctrl_if u_ctl_if ();

  link_train_ctrl #(
    .INIT_LEN  (INIT_LEN),
    .DELAY_LEN (DELAY_LEN),
    .DATA_LEN  (DATA_LEN)
  ) u_link_train_ctrl (
    .CLK    (CLK),
    .RSTX   (RSTX),
    .DOPULL (DOPULL),
    .CLR    (CLR),
    .ctl    (u_ctl_if.ctrl)
  );

  train_pattern_gen u_train_pattern_gen (
    .CLK          (CLK),
    .RSTX         (RSTX),
    .ctl          (u_ctl_if.pattern),
    .pattern_byte (pattern_byte),
    .PHY_INIT     (PHY_INIT)
  );

  prbs_byte_gen u_prbs_byte_gen (
    .CLK       (CLK),
    .RSTX      (RSTX),
    .ctl       (u_ctl_if.prbs),
    .prbs_next (prbs_next)
  );

  tx_lane_out u_tx_lane_out (
    .CLK          (CLK),
    .RSTX         (RSTX),
    .ctl          (u_ctl_if.lane),
    .pattern_byte (pattern_byte),
    .prbs_next    (prbs_next),
    .DOUT         (DOUT),
    .DOPUSH       (DOPUSH)
  );

endmodule

`default_nettype wire

// File: tb/link_tx_sva.sv
`timescale 1ns/10ps
`default_nettype none

module link_tx_sva (
  input  logic             CLK,
  input  logic             RSTX,
  input  logic             DOPULL,
  input  logic             CLR,
  input  logic             DOPUSH,
  input  logic             PHY_INIT,
  input  link_pkg::byte_t  DOUT
);

  // ##########################################################
  // Handshake
  // ##########################################################

  // A byte only appears one cycle after the sink pulled
  push_after_pull: assert property (
    @(posedge CLK) disable iff (!RSTX)
      DOPUSH |-> $past(DOPULL)
  ) else $error("DOPUSH without DOPULL in the previous cycle");

  // ##########################################################
  // Clear and reset
  // ##########################################################

  clear_zeroes_outputs: assert property (
    @(posedge CLK) disable iff (!RSTX)
      CLR |=> (!DOPUSH && !PHY_INIT && (DOUT == '0))
  ) else $error("outputs not zero in the cycle after CLR");

  reset_zeroes_outputs: assert property (
    @(posedge CLK)
      !RSTX |-> (!DOPUSH && !PHY_INIT && (DOUT == '0))
  ) else $error("outputs not zero during reset");

endmodule

bind link_tx_top link_tx_sva u_link_tx_sva (
  .CLK      (CLK),
  .RSTX     (RSTX),
  .DOPULL   (DOPULL),
  .CLR      (CLR),
  .DOPUSH   (DOPUSH),
  .PHY_INIT (PHY_INIT),
  .DOUT     (DOUT)
);

`default_nettype wire

// File: tb/tb_link_tx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_link_tx;
  import link_pkg::*;

  localparam int INIT_LEN   = 64;
  localparam int DELAY_LEN  = 256;
  localparam int DATA_LEN   = 1024;
  localparam int LOOP_BYTES = DELAY_LEN + 1 + DATA_LEN;  // Bytes per training loop
  localparam int LOOP_PULLS = INIT_LEN + LOOP_BYTES;
  // Four loops at a 7/8 pull rate, doubled
  localparam int WATCHDOG_CYCLES = 2 * 4 * LOOP_PULLS * 8 / 7;

  localparam logic [7:0] TOGGLE = 8'hAA;
  localparam logic [7:0] ALIGN  = 8'h93;
  localparam logic [7:0] SEED   = 8'h01;
  localparam logic [7:0] TAPS   = 8'hB8;

  logic        CLK;
  logic        RSTX;
  logic        DOPULL;
  logic        CLR;
  logic        DOPUSH;
  logic        PHY_INIT;
  byte_t       DOUT;

  // Reference model state
  link_phase_e m_phase     = INIT;
  int          m_cnt       = 0;
  int          m_idx       = 0;     // Byte index inside the phase
  logic [7:0]  m_prbs      = 8'h01;
  logic        exp_push    = 1'b0;
  logic        exp_phy     = 1'b0;
  logic [7:0]  exp_dout    = 8'h00;

  int          rx_bytes    = 0;
  int          n_align     = 0;
  int          n_loops     = 0;
  int          n_clears    = 0;
  int          n_phy_holds = 0;
  logic [31:0] lfsr_q      = 32'h113a;
  int          stim_cyc    = 0;

  link_tx_top #(
    .INIT_LEN  (INIT_LEN),
    .DELAY_LEN (DELAY_LEN),
    .DATA_LEN  (DATA_LEN)
  ) u_link_tx_top (
    .CLK      (CLK),
    .RSTX     (RSTX),
    .DOPULL   (DOPULL),
    .CLR      (CLR),
    .DOPUSH   (DOPUSH),
    .PHY_INIT (PHY_INIT),
    .DOUT     (DOUT)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // ##########################################################
  // Helpers
  // ##########################################################

  function automatic logic [7:0] prbs_step(input logic [7:0] s);
    return {1'b0, s[7:1]} ^ (s[0] ? TAPS : 8'h00);
  endfunction

  function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic logic next_rand_bit();
    logic b;
    b = lfsr_q[0];
    lfsr_q = lfsr_advance(lfsr_q);
    return b;
  endfunction

  function automatic logic pick_pull(input int cyc);
    int         slot;
    logic [2:0] draw;
    slot = cyc % 512;
    if (slot >= 128 && slot < 224) begin
      return 1'b1;  // Full rate stretch
    end
    if (slot >= 320 && slot < 340) begin
      return 1'b0;  // Sink stalls 20 cycles
    end
    draw[0] = next_rand_bit();
    draw[1] = next_rand_bit();
    draw[2] = next_rand_bit();
    return |draw;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [7:0] exp,
                                 input logic [7:0] got);
    stop_with_failure($sformatf("mismatch %s: expected 0x%02h, got 0x%02h", name, exp, got));
  endtask

  task automatic pull_until(input int target);
    while (rx_bytes < target) begin
      @(posedge CLK);
      #1;
      DOPULL = pick_pull(stim_cyc);
      stim_cyc++;
    end
  endtask

  // ##########################################################
  // Reference model, one step per clock
  // ##########################################################

  always @(posedge CLK or negedge RSTX) begin
    if (!RSTX || CLR) begin
      if (RSTX) begin
        n_clears++;
      end
      m_phase  = INIT;
      m_cnt    = INIT_LEN - 1;
      m_idx    = 0;
      m_prbs   = SEED;
      exp_push = 1'b0;
      exp_phy  = 1'b0;
      exp_dout = 8'h00;
    end else if (DOPULL) begin
      if (m_cnt == 0) begin
        m_idx = 0;
        case (m_phase)
          INIT: begin
            m_phase = DELAY_ADJUST;
            m_cnt   = DELAY_LEN - 1;
          end
          DELAY_ADJUST: begin
            m_phase = WORD_ALIGN;
            m_cnt   = 0;
          end
          WORD_ALIGN: begin
            m_phase = DATA_TRANSFER;
            m_cnt   = DATA_LEN - 1;
          end
          default: begin
            m_phase = DELAY_ADJUST;  // Back to training
            m_cnt   = DELAY_LEN - 1;
            n_loops++;
          end
        endcase
      end else begin
        m_cnt--;
        m_idx++;
      end
      exp_push = (m_phase != INIT);
      exp_phy  = 1'b0;
      case (m_phase)
        DELAY_ADJUST: begin
          exp_dout = (m_idx >= 32 && m_idx <= 222) ? TOGGLE : 8'h00;
          exp_phy  = (m_idx >= 60 && m_idx <= 190);
        end
        WORD_ALIGN: begin
          exp_dout = ALIGN;
          n_align++;
        end
        DATA_TRANSFER: begin
          m_prbs   = prbs_step(prbs_step(m_prbs));
          exp_dout = m_prbs;
        end
        default: exp_dout = 8'h00;
      endcase
    end else begin
      exp_push = 1'b0;  // DOUT and PHY_INIT hold
      if (exp_phy) begin
        n_phy_holds++;
      end
    end
  end

  // Outputs are settled at the falling edge
  always @(negedge CLK) begin
    assert (DOPUSH === exp_push) else report_mismatch("DOPUSH", exp_push, DOPUSH);
    assert (PHY_INIT === exp_phy) else report_mismatch("PHY_INIT", exp_phy, PHY_INIT);
    assert (DOUT === exp_dout) else report_mismatch("DOUT", exp_dout, DOUT);
    if (DOPUSH === 1'b1) begin
      rx_bytes++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    stop_with_failure($sformatf("timeout: stimulus not done after %0d cycles", WATCHDOG_CYCLES));
  end

  // ##########################################################
  // Stimulus
  // ##########################################################

  initial begin
    int base;
    RSTX   = 1'b0;
    DOPULL = 1'b0;
    CLR    = 1'b0;
    repeat (16) @(posedge CLK);
    #1;
    RSTX = 1'b1;
    pull_until(2 * LOOP_BYTES);
    pull_until(2 * LOOP_BYTES + DELAY_LEN + 1 + DATA_LEN / 2);  // Middle of a data frame
    @(posedge CLK);
    #1;
    CLR    = 1'b1;
    DOPULL = pick_pull(stim_cyc);
    stim_cyc++;
    @(posedge CLK);
    #1;
    CLR  = 1'b0;
    base = rx_bytes;
    pull_until(base + LOOP_BYTES + 16);  // Into the next delay adjust
    @(posedge CLK);
    #1;
    DOPULL = 1'b0;
    repeat (4) @(posedge CLK);
    if (n_align == 4 && n_loops == 3 && n_clears == 1 && n_phy_holds > 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      stop_with_failure($sformatf("sequence incomplete: %0d aligns, %0d loops, %0d clears",
                                  n_align, n_loops, n_clears));
    end
  end

endmodule

`default_nettype wire

// File: src.f
src/link_pkg.sv
src/link_ctrl_if.sv
src/link_train_ctrl.sv
src/train_pattern_gen.sv
src/prbs_byte_gen.sv
src/tx_lane_out.sv
src/link_tx_top.sv
tb/link_tx_sva.sv
tb/tb_link_tx.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the link transmitter testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_link_tx \
  -Mdir "$BUILD_DIR" \
  -f src.f

# The log decides the result, so the simulator status is not used here
"./$BUILD_DIR/Vtb_link_tx" +verilator+error+limit+100 2>&1 | tee "$LOG"

if grep -q "^Regression passed$" "$LOG"; then
  echo "run.sh: PASS"
  exit 0
else
  echo "run.sh: FAIL, see $LOG"
  exit 1
fi
